// ==== hw/div_pkg.sv ====
package div_pkg;

	// ==============================
	// widths and round count
	// ==============================

	localparam int DIV_WIDTH      = 32;
	localparam int DIV_DIGIT_BITS = 2; // two quotient bits per round, so radix 4.
	localparam int DIV_ROUNDS     = DIV_WIDTH / DIV_DIGIT_BITS;
	localparam int DIV_ROUND_BITS = $clog2(DIV_ROUNDS);

	// ==============================
	// operations and payloads
	// ==============================

	typedef enum logic [1:0] {
		OP_DIV  = 2'd0,
		OP_DIVU = 2'd1,
		OP_REM  = 2'd2,
		OP_REMU = 2'd3
	} div_op_e;

	typedef struct packed {
		div_op_e                op;
		logic [DIV_WIDTH-1:0]   dividend;
		logic [DIV_WIDTH-1:0]   divisor;
	} div_cmd_t;

	typedef struct packed {
		logic [DIV_WIDTH-1:0]   dividend_mag;
		logic [DIV_WIDTH-1:0]   divisor_mag;
		logic                   neg_quo;
		logic                   neg_rem;
		logic                   want_rem;
		logic                   div_zero;
		logic [DIV_WIDTH-1:0]   dividend; // original operand, returned as remainder on x/0.
	} div_job_t;

	typedef struct packed {
		logic [DIV_WIDTH-1:0]   quotient;
		logic [DIV_WIDTH-1:0]   remainder;
	} div_raw_t;

endpackage

// ==== hw/div_radix4_stage.sv ====
`timescale 1ns/1ps

module div_radix4_stage #(
	parameter int WIDTH = 32
) (
	input  logic [1:0]       digit,
	input  logic [WIDTH-1:0] divisor,
	input  logic [WIDTH-1:0] rem_in,
	output logic [WIDTH-1:0] rem_out,
	output logic [1:0]       q_bits
);

	logic [WIDTH:0] row_hi; // quotient bit on top, partial remainder below.
	logic [WIDTH:0] row_lo;

	function automatic logic [WIDTH:0] restore_row(
		input logic [WIDTH-1:0] rem,
		input logic             bit_in,
		input logic [WIDTH-1:0] d
	);
		logic [WIDTH:0]   shifted;
		logic [WIDTH+1:0] diff;
		shifted = {rem, bit_in};
		diff    = {1'b0, shifted} - {2'b00, d}; // the top bit is the borrow.
		if (diff[WIDTH+1]) begin
			return {1'b0, shifted[WIDTH-1:0]};
		end
		return {1'b1, diff[WIDTH-1:0]};
	endfunction

	assign row_hi  = restore_row(rem_in, digit[1], divisor);
	assign row_lo  = restore_row(row_hi[WIDTH-1:0], digit[0], divisor);
	assign q_bits  = {row_hi[WIDTH], row_lo[WIDTH]};
	assign rem_out = row_lo[WIDTH-1:0];

endmodule

// ==== hw/div_round_sequencer.sv ====
`timescale 1ns/1ps

module div_round_sequencer (
	input  logic                               clk,
	input  logic                               reset,
	input  logic                               go,
	output logic [div_pkg::DIV_ROUND_BITS-1:0] round,
	output logic                               first,
	output logic                               step,
	output logic                               exec_done
);
	import div_pkg::*;

	typedef enum logic {
		ST_IDLE,
		ST_RUN
	} seq_state_e;

	seq_state_e                state;
	logic [DIV_ROUND_BITS-1:0] count;
	logic                      last;

	// round 0 runs in the go cycle itself, rounds 1 to 15 in the running state.
	assign first = (state == ST_IDLE) && go;
	assign step  = first || (state == ST_RUN);
	assign round = count;
	assign last  = (state == ST_RUN) && (count == DIV_ROUND_BITS'(DIV_ROUNDS - 1));

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			state     <= ST_IDLE;
			count     <= '0;
			exec_done <= 1'b0;
		end else begin
			exec_done <= last;
			if (first) begin
				state <= ST_RUN;
			end else if (last) begin
				state <= ST_IDLE;
			end
			if (step) begin
				count <= count + 1'b1; // wraps back to zero after the last round.
			end
		end
	end

	// ==============================
	// checks
	// ==============================

	go_only_when_idle: assert property (
		@(posedge clk) disable iff (!reset)
		(state == ST_RUN) |-> !go
	);

endmodule

// ==== hw/div_decode.sv ====
`timescale 1ns/1ps

module div_decode (
	input  logic              clk,
	input  logic              reset,
	input  logic              start,
	input  div_pkg::div_cmd_t cmd,
	input  logic              busy,
	output logic              go,
	output div_pkg::div_job_t job
);
	import div_pkg::*;

	logic                 accept;
	logic                 is_signed;
	logic                 a_neg;
	logic                 b_neg;
	logic                 zero_div;
	logic [DIV_WIDTH-1:0] a_mag;
	logic [DIV_WIDTH-1:0] b_mag;

	assign accept    = start && !busy; // commands during a division are dropped.
	assign is_signed = (cmd.op == OP_DIV) || (cmd.op == OP_REM);
	assign a_neg     = is_signed && cmd.dividend[DIV_WIDTH-1];
	assign b_neg     = is_signed && cmd.divisor[DIV_WIDTH-1];
	assign zero_div  = (cmd.divisor == '0);

	assign a_mag = a_neg ? -cmd.dividend : cmd.dividend; // the most negative value maps to itself.
	assign b_mag = b_neg ? -cmd.divisor : cmd.divisor;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			go <= 1'b0;
		end else begin
			go <= accept;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			job.dividend_mag <= a_mag;
			job.divisor_mag  <= b_mag;
			job.neg_quo      <= (a_neg ^ b_neg) && !zero_div;
			job.neg_rem      <= a_neg; // remainder follows the dividend sign.
			job.want_rem     <= (cmd.op == OP_REM) || (cmd.op == OP_REMU);
			job.div_zero     <= zero_div;
			job.dividend     <= cmd.dividend;
		end
	end

	// a new job starts only as the top level raises busy for it.
	go_not_while_busy: assert property (
		@(posedge clk) disable iff (!reset)
		$rose(go) |-> $rose(busy)
	);

endmodule

// ==== hw/div_execute.sv ====
`timescale 1ns/1ps

module div_execute (
	input  logic              clk,
	input  logic              reset,
	input  logic              go,
	input  div_pkg::div_job_t job,
	output logic              exec_done,
	output div_pkg::div_raw_t raw,
	output div_pkg::div_job_t job_out
);
	import div_pkg::*;

	logic [DIV_ROUND_BITS-1:0] round;
	logic                      first;
	logic                      step;
	div_job_t                  job_q;
	div_job_t                  job_cur;
	logic [DIV_ROUND_BITS:0]   digit_lsb;
	logic [DIV_DIGIT_BITS-1:0] digit;
	logic [DIV_WIDTH-1:0]      rem_q;
	logic [DIV_WIDTH-1:0]      rem_in;
	logic [DIV_WIDTH-1:0]      rem_next;
	logic [DIV_WIDTH-1:0]      quo_q;
	logic [DIV_DIGIT_BITS-1:0] q_bits;

	div_round_sequencer i_div_round_sequencer (
		.clk       (clk),
		.reset     (reset),
		.go        (go),
		.round     (round),
		.first     (first),
		.step      (step),
		.exec_done (exec_done)
	);

	div_radix4_stage #(
		.WIDTH (DIV_WIDTH)
	) i_div_radix4_stage (
		.digit   (digit),
		.divisor (job_cur.divisor_mag),
		.rem_in  (rem_in),
		.rem_out (rem_next),
		.q_bits  (q_bits)
	);

	assign job_cur = first ? job : job_q; // the local copy is only loaded at the end of round 0.

	// round 0 takes bits 31:30, round 15 takes bits 1:0.
	assign digit_lsb = {~round, 1'b0};
	assign digit     = job_cur.dividend_mag[digit_lsb +: DIV_DIGIT_BITS];
	assign rem_in    = first ? '0 : rem_q;

	always_ff @(posedge clk) begin
		if (go) begin
			job_q <= job;
		end
		if (step) begin
			rem_q <= rem_next;
			quo_q <= {quo_q[DIV_WIDTH-DIV_DIGIT_BITS-1:0], q_bits};
		end
	end

	assign raw.quotient  = quo_q;
	assign raw.remainder = rem_q;
	assign job_out       = job_q;

endmodule

// ==== hw/div_result.sv ====
`timescale 1ns/1ps

module div_result (
	input  logic                            clk,
	input  logic                            reset,
	input  logic                            exec_done,
	input  div_pkg::div_raw_t               raw,
	input  div_pkg::div_job_t               job,
	output logic                            done,
	output logic [div_pkg::DIV_WIDTH-1:0]   result
);
	import div_pkg::*;

	logic [DIV_WIDTH-1:0] quo_fix;
	logic [DIV_WIDTH-1:0] rem_fix;
	logic [DIV_WIDTH-1:0] word;

	always_comb begin
		quo_fix = job.neg_quo ? -raw.quotient : raw.quotient;
		rem_fix = job.neg_rem ? -raw.remainder : raw.remainder;
		if (job.div_zero) begin
			quo_fix = '1;
			rem_fix = job.dividend; // x/0 leaves the dividend as remainder.
		end
		word = job.want_rem ? rem_fix : quo_fix;
	end

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			done   <= 1'b0;
			result <= '0;
		end else begin
			done <= exec_done;
			if (exec_done) begin
				result <= word; // held until the next completion.
			end
		end
	end

endmodule

// ==== hw/div_unit.sv ====
`timescale 1ns/1ps

module div_unit (
	input  logic                          clk,
	input  logic                          reset,
	input  logic                          start,
	input  div_pkg::div_cmd_t             cmd,
	output logic                          busy,
	output logic                          done,
	output logic [div_pkg::DIV_WIDTH-1:0] result
);
	import div_pkg::*;

	logic     go;
	logic     exec_done;
	div_job_t job;
	div_job_t job_exec;
	div_raw_t raw;

	// ==============================
	// busy tracking
	// ==============================

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			busy <= 1'b0;
		end else if (exec_done) begin
			busy <= 1'b0; // drops in the same cycle that done is high.
		end else if (start && !busy) begin
			busy <= 1'b1;
		end
	end

	div_decode i_div_decode (
		.clk   (clk),
		.reset (reset),
		.start (start),
		.cmd   (cmd),
		.busy  (busy),
		.go    (go),
		.job   (job)
	);

	div_execute i_div_execute (
		.clk       (clk),
		.reset     (reset),
		.go        (go),
		.job       (job),
		.exec_done (exec_done),
		.raw       (raw),
		.job_out   (job_exec)
	);

	div_result i_div_result (
		.clk       (clk),
		.reset     (reset),
		.exec_done (exec_done),
		.raw       (raw),
		.job       (job_exec),
		.done      (done),
		.result    (result)
	);

endmodule

// ==== sim/div_unit_tb.sv ====
`timescale 1ns/1ps

module div_unit_tb;
	import div_pkg::*;

	localparam int DONE_TIMEOUT = 40;
	localparam int DONE_LATENCY = 17; // edges after the sampling edge, edge 18 counting it as 1.

	logic        clk;
	logic        reset;
	logic        start;
	div_cmd_t    cmd;
	logic        busy;
	logic        done;
	logic [31:0] result;
	logic [15:0] lfsr;

	div_unit i_div_unit (
		.clk    (clk),
		.reset  (reset),
		.start  (start),
		.cmd    (cmd),
		.busy   (busy),
		.done   (done),
		.result (result)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ==============================
	// stimulus and reference
	// ==============================

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			bits = {bits[30:0], lfsr[15]};
			lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]}; // taps 16 14 13 11.
		end
		return bits;
	endfunction

	function automatic logic [31:0] expected_result(input div_op_e op, input logic [31:0] a,
			input logic [31:0] b);
		logic        sgn;
		logic        rem_op;
		logic [31:0] ma;
		logic [31:0] mb;
		logic [31:0] q;
		logic [31:0] r;
		sgn    = (op == OP_DIV) || (op == OP_REM);
		rem_op = (op == OP_REM) || (op == OP_REMU);
		if (b == 32'd0) return rem_op ? a : 32'hffff_ffff;
		ma = (sgn && a[31]) ? 32'd0 - a : a;
		mb = (sgn && b[31]) ? 32'd0 - b : b;
		q  = ma / mb;
		r  = ma % mb;
		if (sgn && (a[31] != b[31])) q = 32'd0 - q;
		if (sgn && a[31]) r = 32'd0 - r; // the remainder takes the dividend's sign.
		return rem_op ? r : q;
	endfunction

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("MISMATCH %s expected %h actual %h", name, expected, actual);
			$display("TESTBENCH FAILED");
			$fatal(1);
		end
	endtask

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic issue(input div_op_e op, input logic [31:0] a, input logic [31:0] b);
		start        = 1'b1;
		cmd.op       = op;
		cmd.dividend = a;
		cmd.divisor  = b;
		@(posedge clk);
		#1;
		start = 1'b0;
	endtask

	task automatic wait_done(input string name, inout int edges);
		while (!done) begin
			if (edges >= DONE_TIMEOUT) fail_now({name, ": done did not arrive in time"});
			@(posedge clk);
			#1;
			edges++;
		end
	endtask

	task automatic run_check(input string name, input div_op_e op, input logic [31:0] a,
			input logic [31:0] b);
		int edges;
		edges = 0;
		issue(op, a, b);
		wait_done(name, edges);
		check_value(name, expected_result(op, a, b), result);
	endtask

	// ==============================
	// directed tests
	// ==============================

	task automatic test_unsigned();
		logic [31:0] pair_a [6] = '{32'd100, 32'd7, 32'hffff_ffff, 32'hffff_ffff,
			32'hffff_ffff, 32'h1234_5678};
		logic [31:0] pair_b [6] = '{32'd7, 32'd100, 32'hffff_ffff, 32'd1, 32'd3, 32'd1000};
		check_value("reset_busy", 32'd0, {31'd0, busy});
		check_value("reset_done", 32'd0, {31'd0, done});
		check_value("reset_result", 32'd0, result);
		for (int i = 0; i < 6; i++) begin
			run_check("unsigned_quotient", OP_DIVU, pair_a[i], pair_b[i]);
			run_check("unsigned_remainder", OP_REMU, pair_a[i], pair_b[i]);
		end
	endtask

	task automatic test_signed();
		logic [31:0] a;
		logic [31:0] b;
		for (int i = 0; i < 4; i++) begin
			a = i[0] ? -32'sd17 : 32'sd17;
			b = i[1] ? -32'sd5 : 32'sd5;
			run_check("signed_quotient", OP_DIV, a, b);
			run_check("signed_remainder", OP_REM, a, b);
		end
	endtask

	task automatic test_divide_by_zero();
		for (int j = 0; j < 4; j++) begin
			run_check("div_zero", div_op_e'(j[1:0]), 32'h8000_1234, 32'd0);
			run_check("div_zero_small", div_op_e'(j[1:0]), 32'd5, 32'd0);
		end
	endtask

	task automatic test_random();
		logic [31:0] sel;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] shift;
		for (int i = 0; i < 200; i++) begin
			sel   = take_bits(2);
			a     = take_bits(32);
			b     = take_bits(32);
			shift = take_bits(5);
			b     = b >> shift; // mixes small and large divisors.
			run_check("random", div_op_e'(sel[1:0]), a, b);
		end
	endtask

	task automatic test_busy_ignore();
		int          edges;
		logic [31:0] want;
		want  = expected_result(OP_DIVU, 32'd1000, 32'd7);
		edges = 0;
		issue(OP_DIVU, 32'd1000, 32'd7);
		check_value("busy_after_start", 32'd1, {31'd0, busy});
		for (int i = 0; i < 3; i++) begin
			@(posedge clk);
			#1;
			edges++;
		end
		issue(OP_DIV, 32'hffff_ff00, 32'd3);
		edges++;
		wait_done("busy_ignore", edges);
		check_value("busy_ignore_latency", DONE_LATENCY, edges);
		check_value("busy_ignore_result", want, result);
		check_value("busy_in_done_cycle", 32'd0, {31'd0, busy});
		for (int i = 0; i < 25; i++) begin
			@(posedge clk);
			#1;
			assert (!done) else fail_now("a second done followed a start that arrived while busy");
		end
		check_value("busy_ignore_held", want, result);
	endtask

	initial begin
		lfsr  = 16'd59355;
		reset = 1'b0;
		start = 1'b0;
		cmd   = '0;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b1;
		test_unsigned();
		test_signed();
		test_divide_by_zero();
		run_check("overflow_quotient", OP_DIV, 32'h8000_0000, 32'hffff_ffff);
		run_check("overflow_remainder", OP_REM, 32'h8000_0000, 32'hffff_ffff);
		test_random();
		test_busy_ignore();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== list.f ====
hw/div_pkg.sv
hw/div_radix4_stage.sv
hw/div_round_sequencer.sv
hw/div_decode.sv
hw/div_execute.sv
hw/div_result.sv
hw/div_unit.sv
sim/div_unit_tb.sv

// ==== Makefile ====
SOURCES := $(filter-out +%,$(shell cat list.f))
BIN := obj_dir/Vdiv_unit_tb

.PHONY: run clean

run: $(BIN)
	./$(BIN)

$(BIN): $(SOURCES) list.f
	verilator --binary --timing --assert -Wno-fatal --top-module div_unit_tb \
		-f list.f --Mdir obj_dir -o Vdiv_unit_tb

clean:
	rm -rf obj_dir
